// File: logic/fpu_compare.sv
`timescale 1ns/100ps
`default_nettype none
`include "fpu_macros.svh"

module fpu_compare (
  fpu_req_if.unit              req,
  output logic [`FPU_XLEN-1:0] result
);
  import fpu_op_pkg::*;
  import fpu_fmt_pkg::*;

  sp_float_t fa, fb;
  logic a_nan, b_nan;
  logic both_zero;          // +0 and -0 compare equal
  logic mag_lt, mag_eq;
  logic ord_lt;             // total order, -0 below +0
  logic lt, eq;

  assign fa = req.a.f;
  assign fb = req.b.f;

  assign a_nan     = (fa.exp == 8'hff) && (fa.man != '0);
  assign b_nan     = (fb.exp == 8'hff) && (fb.man != '0);
  assign both_zero = ({fa.exp, fa.man} == '0) && ({fb.exp, fb.man} == '0);

  // exponent then mantissa
  assign mag_lt = {fa.exp, fa.man} < {fb.exp, fb.man};
  assign mag_eq = {fa.exp, fa.man} == {fb.exp, fb.man};

  assign ord_lt = (fa.sign != fb.sign) ? fa.sign
                : (fa.sign ? (~mag_lt & ~mag_eq) : mag_lt);   // negatives reversed
  assign lt     = ord_lt & ~both_zero;
  assign eq     = (req.a.i == req.b.i) | both_zero;

  always_comb begin
    case (req.op)
      feq: result = {31'd0, ~a_nan & ~b_nan & eq};
      flt: result = {31'd0, ~a_nan & ~b_nan & lt};
      fle: result = {31'd0, ~a_nan & ~b_nan & (lt | eq)};
      fmin, fmax: begin
        if (a_nan && b_nan)
          result = `FPU_CANON_NAN;
        else if (a_nan)
          result = req.b.i;   // take the number
        else if (b_nan)
          result = req.a.i;
        else if (ord_lt ^ (req.op == fmax))
          result = req.a.i;
        else
          result = req.b.i;
      end
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/fpu_cvt_unit.sv
`timescale 1ns/100ps
`default_nettype none
`include "fpu_macros.svh"

module fpu_cvt_unit (
  input  logic                 g_clk,
  input  logic                 g_rst,
  fpu_req_if.unit              req,
  output logic [`FPU_XLEN-1:0] result,
  output logic                 done
);
  import fpu_op_pkg::*;

  typedef enum logic [1:0] {st_idle, st_setup, st_shift, st_pack} cvt_state_e;

  cvt_state_e state_q;
  logic       is_f2i, is_uns;
  logic       i_neg;                  // negative signed integer input
  logic [31:0] i_mag;
  logic signed [9:0] ue;              // unbiased exponent
  logic       fix_now;                // result known without shifting
  logic [31:0] fix_word;
  logic       shift_done;
  logic [31:0] acc_q;                 // magnitude being shifted
  logic [7:0] exp_q;                  // int to float exponent
  logic signed [5:0] sh_q;            // float to int shifts left to go
  logic       neg_q;
  logic       fixed_q;

  assign is_f2i = (req.op == cvt_w_s) || (req.op == cvt_wu_s);
  assign is_uns = (req.op == cvt_s_wu) || (req.op == cvt_wu_s);
  assign i_neg  = ~is_uns & req.a.i[31];
  assign i_mag  = i_neg ? -req.a.i : req.a.i;
  assign ue     = $signed({2'b00, req.a.f.exp}) - $signed(10'(`FPU_EXP_BIAS));

  ////////////////////
  // special cases, rtz
  always_comb begin
    fix_now  = 1'b1;
    fix_word = '0;
    if (!is_f2i)
      fix_now = (req.a.i == '0);   // zero packs as +0 at once
    else if (req.a.f.exp == 8'hff && req.a.f.man != '0)
      fix_word = is_uns ? 32'hffff_ffff : 32'h7fff_ffff;   // nan
    else if (ue < 10'sd0)
      fix_word = '0;               // |x| < 1, -0.x included
    else if (is_uns && req.a.f.sign)
      fix_word = '0;
    else if (is_uns && ue > 10'sd31)
      fix_word = 32'hffff_ffff;
    else if (!is_uns && ue > 10'sd30)
      fix_word = req.a.f.sign ? 32'h8000_0000 : 32'h7fff_ffff;
    else
      fix_now = 1'b0;
  end

  assign shift_done = is_f2i ? (sh_q == 6'sd0) : acc_q[31];

  always_ff @(posedge g_clk) begin
    if (g_rst) begin
      state_q <= st_idle;
    end else begin
      case (state_q)
        st_idle:  if (req.start) state_q <= st_setup;
        st_setup: state_q <= fix_now ? st_pack : st_shift;
        st_shift: if (shift_done) state_q <= st_pack;
        default:  state_q <= st_idle;   // pack lasts one cycle
      endcase
    end
  end

  ////////////////////
  // datapath
  always_ff @(posedge g_clk) begin
    case (state_q)
      st_setup: begin
        fixed_q <= fix_now;
        neg_q   <= is_f2i ? req.a.f.sign : i_neg;
        exp_q   <= 8'(`FPU_EXP_BIAS + 31);   // msb at bit 31
        sh_q    <= 6'(ue - 10'sd23);
        if (fix_now)
          acc_q <= fix_word;
        else if (is_f2i)
          acc_q <= {8'h00, 1'b1, req.a.f.man};   // hidden bit restored
        else
          acc_q <= i_mag;
      end
      st_shift: begin
        if (!is_f2i) begin
          if (!acc_q[31]) begin   // normalize
            acc_q <= acc_q << 1;
            exp_q <= exp_q - 8'd1;
          end
        end else if (sh_q > 6'sd0) begin
          acc_q <= acc_q << 1;
          sh_q  <= sh_q - 6'sd1;
        end else if (sh_q < 6'sd0) begin
          acc_q <= acc_q >> 1;   // dropped bits truncate
          sh_q  <= sh_q + 6'sd1;
        end
      end
      default: ;
    endcase
  end

  always_comb begin
    if (fixed_q)
      result = acc_q;
    else if (!is_f2i)
      result = {neg_q, exp_q, acc_q[30:8]};   // mantissa truncated
    else
      result = neg_q ? -acc_q : acc_q;
  end

  assign done = (state_q == st_pack);

endmodule

`default_nettype wire

// File: logic/fpu_fmt_pkg.sv
`default_nettype none

package fpu_fmt_pkg;

  // ieee 754 single precision layout
  typedef struct packed {
    logic       sign;
    logic [7:0] exp;
    logic [22:0] man;   // fraction, hidden bit not stored
  } sp_float_t;

  // one operand word, float view or raw integer view
  typedef union packed {
    sp_float_t   f;
    logic [31:0] i;
  } fpu_word_u;

  // fclass result bit positions, lsb first
  typedef enum logic [3:0] {
    cls_neg_inf  = 4'd0,
    cls_neg_norm = 4'd1,
    cls_neg_sub  = 4'd2,
    cls_neg_zero = 4'd3,
    cls_pos_zero = 4'd4,
    cls_pos_sub  = 4'd5,
    cls_pos_norm = 4'd6,
    cls_pos_inf  = 4'd7,
    cls_snan     = 4'd8,
    cls_qnan     = 4'd9
  } fclass_bit_e;

endpackage

`default_nettype wire

// File: logic/fpu_issue_ctrl.sv
`timescale 1ns/100ps
`default_nettype none
`include "fpu_macros.svh"

module fpu_issue_ctrl (
  input  logic                 g_clk,
  input  logic                 g_rst,
  input  logic                 op_valid,
  input  logic [4:0]           op_sel,
  input  logic [`FPU_XLEN-1:0] op_a,
  input  logic [`FPU_XLEN-1:0] op_b,
  fpu_req_if.issue             req,
  input  logic [`FPU_XLEN-1:0] cvt_result,
  input  logic                 cvt_done,
  input  logic [`FPU_XLEN-1:0] cmp_result,
  input  logic [`FPU_XLEN-1:0] sgn_result,
  output logic                 busy,
  output logic                 res_valid,
  output logic [`FPU_XLEN-1:0] res
);
  import fpu_op_pkg::*;

  logic      accept;
  fpu_unit_e new_unit;   // unit of the incoming op
  fpu_unit_e unit_q;     // unit of the latched op
  logic      pend_q;     // single cycle result waiting to be registered
  logic [`FPU_XLEN-1:0] comb_sel;

  assign accept = op_valid & ~busy;

  ////////////////////
  // op decode
  always_comb begin
    case (fpu_op_e'(op_sel))
      fsgnj, fsgnjn, fsgnjx, fmv_x_w, fclass, fmv_w_x:
        new_unit = unit_sgn;
      fmax, fmin, feq, flt, fle:
        new_unit = unit_cmp;
      cvt_s_w, cvt_s_wu, cvt_w_s, cvt_wu_s:
        new_unit = unit_cvt;
      default:
        new_unit = unit_none;   // unsupported code
    endcase
  end

  // operands held until the next accept
  always_ff @(posedge g_clk) begin
    if (accept) begin
      req.op  <= fpu_op_e'(op_sel);
      req.a.i <= op_a;
      req.b.i <= op_b;
      unit_q  <= new_unit;
    end
  end

  // pick the combinational unit output
  always_comb begin
    case (unit_q)
      unit_sgn: comb_sel = sgn_result;
      unit_cmp: comb_sel = cmp_result;
      default:  comb_sel = `FPU_CANON_NAN;
    endcase
  end

  ////////////////////
  // stall and result register
  always_ff @(posedge g_clk) begin
    if (g_rst) begin
      busy      <= 1'b0;
      res_valid <= 1'b0;
      res       <= '0;
      pend_q    <= 1'b0;
      req.start <= 1'b0;
    end else begin
      res_valid <= 1'b0;
      req.start <= accept && (new_unit == unit_cvt);
      pend_q    <= accept && (new_unit != unit_cvt);
      if (pend_q) begin   // one cycle after accept
        res       <= comb_sel;
        res_valid <= 1'b1;
      end
      if (accept && (new_unit == unit_cvt))
        busy <= 1'b1;   // stall until converter done
      if (cvt_done) begin
        busy      <= 1'b0;
        res       <= cvt_result;
        res_valid <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/fpu_macros.svh
`ifndef FPU_MACROS_SVH
`define FPU_MACROS_SVH

// operand and result width
`define FPU_XLEN 32

// single precision exponent bias
`define FPU_EXP_BIAS 127

// quiet nan for invalid or unsupported results
`define FPU_CANON_NAN 32'h7fc0_0000

// worst case cycles from conversion accept to result
`define FPU_CVT_MAX_CYC 36

`endif

// File: logic/fpu_op_pkg.sv
`default_nettype none

package fpu_op_pkg;

  // select codes as issued by the decoder
  typedef enum logic [4:0] {
    fsgnj    = 5'b00101,
    fsgnjn   = 5'b00110,
    fsgnjx   = 5'b00111,
    fmax     = 5'b01000,
    fmin     = 5'b01001,
    feq      = 5'b01010,
    flt      = 5'b01011,
    fle      = 5'b01100,
    fmv_x_w  = 5'b01101,
    fclass   = 5'b01110,
    fmv_w_x  = 5'b01111,
    cvt_s_w  = 5'b10100,   // int to float
    cvt_s_wu = 5'b10101,
    cvt_w_s  = 5'b10110,   // float to int
    cvt_wu_s = 5'b10111
  } fpu_op_e;

  // execution unit that owns an op
  typedef enum logic [1:0] {
    unit_sgn  = 2'd0,
    unit_cmp  = 2'd1,
    unit_cvt  = 2'd2,
    unit_none = 2'd3
  } fpu_unit_e;

endpackage

`default_nettype wire

// File: logic/fpu_req_if.sv
`timescale 1ns/100ps
`default_nettype none

// latched request, issue control to the units
interface fpu_req_if;
  import fpu_op_pkg::*;
  import fpu_fmt_pkg::*;

  logic      start;   // one cycle pulse, conversions only
  fpu_op_e   op;
  fpu_word_u a;
  fpu_word_u b;

  modport issue (output start, op, a, b);
  modport unit  (input  start, op, a, b);

endinterface

`default_nettype wire

// File: logic/fpu_sign_class.sv
`timescale 1ns/100ps
`default_nettype none
`include "fpu_macros.svh"

module fpu_sign_class (
  fpu_req_if.unit              req,
  output logic [`FPU_XLEN-1:0] result
);
  import fpu_op_pkg::*;
  import fpu_fmt_pkg::*;

  sp_float_t   fa;
  fclass_bit_e cls;

  assign fa = req.a.f;

  ////////////////////
  // fclass
  always_comb begin
    if (fa.exp == 8'hff) begin
      if (fa.man == '0)
        cls = fa.sign ? cls_neg_inf : cls_pos_inf;
      else if (fa.man[22])
        cls = cls_qnan;   // quiet bit set
      else
        cls = cls_snan;
    end else if (fa.exp == 8'h00) begin
      if (fa.man == '0)
        cls = fa.sign ? cls_neg_zero : cls_pos_zero;
      else
        cls = fa.sign ? cls_neg_sub : cls_pos_sub;
    end else begin
      cls = fa.sign ? cls_neg_norm : cls_pos_norm;
    end
  end

  always_comb begin
    case (req.op)
      fsgnj:   result = {req.b.f.sign, req.a.i[30:0]};
      fsgnjn:  result = {~req.b.f.sign, req.a.i[30:0]};
      fsgnjx:  result = {fa.sign ^ req.b.f.sign, req.a.i[30:0]};
      fmv_x_w,
      fmv_w_x: result = req.a.i;   // raw bits
      fclass:  result = 32'd1 << cls;
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/fpu_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "fpu_macros.svh"

module fpu_top (
  input  logic                 g_clk,
  input  logic                 g_rst,
  input  logic                 op_valid,
  input  logic [4:0]           op_sel,
  input  logic [`FPU_XLEN-1:0] op_a,
  input  logic [`FPU_XLEN-1:0] op_b,
  output logic                 busy,        // stall, conversion in progress
  output logic                 res_valid,
  output logic [`FPU_XLEN-1:0] res
);

  logic [`FPU_XLEN-1:0] cvt_result;
  logic                 cvt_done;
  logic [`FPU_XLEN-1:0] cmp_result;
  logic [`FPU_XLEN-1:0] sgn_result;

  fpu_req_if req_if ();

  fpu_issue_ctrl fpu_issue_ctrl_i (
    .g_clk      (g_clk),
    .g_rst      (g_rst),
    .op_valid   (op_valid),
    .op_sel     (op_sel),
    .op_a       (op_a),
    .op_b       (op_b),
    .req        (req_if.issue),
    .cvt_result (cvt_result),
    .cvt_done   (cvt_done),
    .cmp_result (cmp_result),
    .sgn_result (sgn_result),
    .busy       (busy),
    .res_valid  (res_valid),
    .res        (res)
  );

  // multicycle
  fpu_cvt_unit fpu_cvt_unit_i (
    .g_clk  (g_clk),
    .g_rst  (g_rst),
    .req    (req_if.unit),
    .result (cvt_result),
    .done   (cvt_done)
  );

  // single cycle units
  fpu_compare fpu_compare_i (
    .req    (req_if.unit),
    .result (cmp_result)
  );

  fpu_sign_class fpu_sign_class_i (
    .req    (req_if.unit),
    .result (sgn_result)
  );

endmodule

`default_nettype wire

// File: project.f
+incdir+logic
logic/fpu_fmt_pkg.sv
logic/fpu_op_pkg.sv
logic/fpu_req_if.sv
logic/fpu_cvt_unit.sv
logic/fpu_compare.sv
logic/fpu_sign_class.sv
logic/fpu_issue_ctrl.sv
logic/fpu_top.sv
sim/fpu_checker.sv
sim/fpu_tb.sv

// File: run.sh
#!/bin/sh
# build the fpu testbench with verilator, run it, pass only on the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module fpu_tb -f project.f -o fpu_sim \
  && ./obj_dir/fpu_sim | tee /dev/stderr | grep -q "^PASS: all tests$" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: sim/fpu_checker.sv
`timescale 1ns/100ps
`default_nettype none
`include "fpu_macros.svh"

module fpu_checker (
  input logic       g_clk,
  input logic       g_rst,
  input logic       op_valid,
  input logic [4:0] op_sel,
  input logic       busy,
  input logic       res_valid,
  input logic       cvt_done
);
  import fpu_op_pkg::*;

  logic cvt_accept;
  int   wait_cyc;   // cycles spent stalled on the current conversion

  assign cvt_accept = op_valid && !busy &&
                      (fpu_op_e'(op_sel) inside {cvt_s_w, cvt_s_wu, cvt_w_s, cvt_wu_s});

  always_ff @(posedge g_clk) begin
    if (g_rst || cvt_done)
      wait_cyc <= 0;
    else if (busy)
      wait_cyc <= wait_cyc + 1;
  end

  ////////////////////
  // handshake and stall

  a_rst_quiet: assert property (@(posedge g_clk) g_rst |=> !res_valid && !busy)
    else $error("result strobe or stall right after reset");

  // nothing slips out while the converter holds the stall
  a_no_issue_busy: assert property (@(posedge g_clk) disable iff (g_rst)
    busy && $past(busy) |-> !res_valid)
    else $error("result strobe in the middle of a stall");

  a_stall_src: assert property (@(posedge g_clk) disable iff (g_rst)
    $rose(busy) |-> $past(cvt_accept))
    else $error("stall raised without a conversion accept");

  a_cvt_bound: assert property (@(posedge g_clk) disable iff (g_rst)
    wait_cyc < `FPU_CVT_MAX_CYC)
    else $error("conversion did not finish in time");

  a_busy_fall: assert property (@(posedge g_clk) disable iff (g_rst)
    $fell(busy) |-> res_valid)
    else $error("stall dropped without a result");

endmodule

bind fpu_issue_ctrl fpu_checker fpu_checker_i (
  .g_clk     (g_clk),
  .g_rst     (g_rst),
  .op_valid  (op_valid),
  .op_sel    (op_sel),
  .busy      (busy),
  .res_valid (res_valid),
  .cvt_done  (cvt_done)
);

`default_nettype wire

// File: sim/fpu_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "fpu_macros.svh"

module fpu_tb;
  import fpu_op_pkg::*;
  import fpu_fmt_pkg::*;

  localparam int n_dir     = 5 * 256 + 27 * 16;   // compares get every operand pair
  localparam int n_rand    = 800;
  localparam int n_tests   = n_dir + n_rand;
  localparam int wd_cycles = n_tests * (`FPU_CVT_MAX_CYC + 4) + 16 + 100;

  // corner operands, float and integer views
  localparam logic [31:0] specials [16] = '{
    32'h0000_0000, 32'h8000_0000, 32'h7f80_0000, 32'hff80_0000,   // +-0, +-inf
    32'h7fc0_0000, 32'h7f80_0001, 32'h0000_0001, 32'h807f_ffff,   // qnan, snan, subnormals
    32'h3f80_0000, 32'hbfc0_0000, 32'h4f80_0000, 32'hcf00_0000,   // 1.0, -1.5, 2^32, -2^31
    32'h7fff_ffff, 32'hffff_ffff, 32'hbf00_0000, 32'h4f7f_ffff    // int max, -1, -0.5, ~2^32
  };

  logic        g_clk;
  logic        g_rst;
  logic        op_valid;
  logic [4:0]  op_sel;
  logic [31:0] op_a;
  logic [31:0] op_b;
  logic        busy;
  logic        res_valid;
  logic [31:0] res;

  logic [31:0] exp_q [$];   // expected results in accept order
  int          acc_q [$];   // cycle of each accept
  bit          cvt_q [$];
  logic [31:0] want;
  int          acc_cyc;
  bit          was_cvt;
  int          cyc;
  int          errors;
  int          checks;
  int          accepts;
  int          results;     // result strobes seen from the DUT

  fpu_top fpu_top_i (
    .g_clk     (g_clk),
    .g_rst     (g_rst),
    .op_valid  (op_valid),
    .op_sel    (op_sel),
    .op_a      (op_a),
    .op_b      (op_b),
    .busy      (busy),
    .res_valid (res_valid),
    .res       (res)
  );

  initial begin
    g_clk = 1'b0;
    forever #50 g_clk = ~g_clk;   // 100 ns period
  end

  ////////////////////
  // reference model

  function automatic logic is_nan(input logic [31:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
  endfunction

  function automatic logic is_zero(input logic [31:0] x);
    return x[30:0] == 31'd0;
  endfunction

  // ordering by sign, then magnitude; -0 sits below +0
  function automatic logic less(input logic [31:0] x, input logic [31:0] y);
    if (x[31] != y[31])
      return x[31];
    if (x[31])
      return x[30:0] > y[30:0];   // bigger magnitude is smaller
    return x[30:0] < y[30:0];
  endfunction

  function automatic logic [31:0] class_mask(input logic [31:0] x);
    fclass_bit_e pos;
    if (x[30:23] == 8'hff && x[22:0] == 23'd0)
      pos = x[31] ? cls_neg_inf : cls_pos_inf;
    else if (x[30:23] == 8'hff)
      pos = x[22] ? cls_qnan : cls_snan;
    else if (is_zero(x))
      pos = x[31] ? cls_neg_zero : cls_pos_zero;
    else if (x[30:23] == 8'h00)
      pos = x[31] ? cls_neg_sub : cls_pos_sub;
    else
      pos = x[31] ? cls_neg_norm : cls_pos_norm;
    return 32'd1 << pos;
  endfunction

  function automatic logic [31:0] int_to_float(input logic [31:0] x, input logic sgn);
    logic        neg;
    logic [31:0] mag;
    int          msb;
    neg = sgn && x[31];
    mag = neg ? -x : x;
    if (mag == 32'd0)
      return 32'd0;
    msb = 31;
    while (!mag[msb])
      msb--;
    mag = mag << (31 - msb);   // leading one to bit 31
    return {neg, 8'(`FPU_EXP_BIAS + msb), mag[30:8]};   // low bits dropped, rtz
  endfunction

  function automatic logic [31:0] float_to_int(input logic [31:0] x, input logic sgn);
    fpu_word_u   w;
    int          e;
    logic [31:0] mag;
    w.i = x;
    e   = int'(w.f.exp) - `FPU_EXP_BIAS;
    if (is_nan(x))
      return sgn ? 32'h7fff_ffff : 32'hffff_ffff;
    if (e < 0)
      return 32'd0;   // |x| < 1
    if (!sgn && w.f.sign)
      return 32'd0;
    if (!sgn && e > 31)
      return 32'hffff_ffff;
    if (sgn && e > 30)
      return w.f.sign ? 32'h8000_0000 : 32'h7fff_ffff;
    mag = {8'h00, 1'b1, w.f.man};
    mag = (e >= 23) ? (mag << (e - 23)) : (mag >> (23 - e));
    return (sgn && w.f.sign) ? -mag : mag;
  endfunction

  function automatic logic [31:0] model(input logic [4:0] sel, input logic [31:0] a,
                                        input logic [31:0] b);
    logic nan_a;
    logic nan_b;
    logic eq;
    logic lt;
    nan_a = is_nan(a);
    nan_b = is_nan(b);
    eq    = (a == b) || (is_zero(a) && is_zero(b));
    lt    = less(a, b) && !(is_zero(a) && is_zero(b));
    case (sel)
      fsgnj:   return {b[31], a[30:0]};
      fsgnjn:  return {~b[31], a[30:0]};
      fsgnjx:  return {a[31] ^ b[31], a[30:0]};
      feq:     return {31'd0, !nan_a && !nan_b && eq};
      flt:     return {31'd0, !nan_a && !nan_b && lt};
      fle:     return {31'd0, !nan_a && !nan_b && (lt || eq)};
      fmin, fmax: begin
        if (nan_a && nan_b)
          return `FPU_CANON_NAN;
        if (nan_a)
          return b;
        if (nan_b)
          return a;
        return (less(a, b) == (sel == fmin)) ? a : b;
      end
      fmv_x_w, fmv_w_x: return a;
      fclass:   return class_mask(a);
      cvt_s_w:  return int_to_float(a, 1'b1);
      cvt_s_wu: return int_to_float(a, 1'b0);
      cvt_w_s:  return float_to_int(a, 1'b1);
      cvt_wu_s: return float_to_int(a, 1'b0);
      default:  return `FPU_CANON_NAN;
    endcase
  endfunction

  function automatic bit is_cvt(input logic [4:0] sel);
    return sel inside {cvt_s_w, cvt_s_wu, cvt_w_s, cvt_wu_s};
  endfunction

  ////////////////////
  // stimulus helpers

  function automatic logic [31:0] pick_operand();
    logic [31:0] w;
    w = $urandom();
    case ($urandom_range(2, 0))
      0: w = specials[4'($urandom_range(15, 0))];
      1: w[30:23] = 8'(`FPU_EXP_BIAS - 2 + $urandom_range(35, 0));   // near the int range
      default: ;
    endcase
    return w;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL t=%0t %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  // called 1 ns after a rising edge, returns 1 ns after the accept edge
  task automatic issue_op(input logic [4:0] sel, input logic [31:0] a, input logic [31:0] b);
    op_valid = 1'b1;
    op_sel   = sel;
    op_a     = a;
    op_b     = b;
    @(negedge g_clk);
    while (busy)   // held steady through the stall
      @(negedge g_clk);
    @(posedge g_clk);
    #1;
    op_valid = 1'b0;
  endtask

  ////////////////////
  // monitor, sampled mid cycle
  always @(negedge g_clk) begin
    if (!g_rst) begin
      cyc = cyc + 1;
      if (res_valid) begin
        results++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("ERROR t=%0t result strobe with no request outstanding", $time);
        end else begin
          want    = exp_q.pop_front();
          acc_cyc = acc_q.pop_front();
          was_cvt = cvt_q.pop_front();
          check_value("res", res, want);
          if (was_cvt)
            check_value("busy", {31'd0, busy}, 32'd0);   // falls with the strobe
          else
            check_value("latency", cyc - acc_cyc, 32'd1);
        end
      end else if (cvt_q.size() != 0 && cvt_q[0]) begin
        check_value("busy", {31'd0, busy}, 32'd1);   // conversion still running
      end
      if (op_valid && !busy) begin   // accepted at the next edge
        exp_q.push_back(model(op_sel, op_a, op_b));
        acc_q.push_back(cyc + 1);
        cvt_q.push_back(is_cvt(op_sel));
        accepts++;
      end
    end
  end

  // watchdog
  initial begin
    repeat (wd_cycles) @(posedge g_clk);
    $display("ERROR: watchdog expired, results stopped coming");
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    logic [4:0] sel;
    void'($urandom(32'hd79f_eb46));
    g_rst    = 1'b1;
    op_valid = 1'b0;
    op_sel   = 5'd0;
    op_a     = 32'd0;
    op_b     = 32'd0;
    cyc      = 0;
    errors   = 0;
    checks   = 0;
    accepts  = 0;
    results  = 0;
    repeat (16) @(posedge g_clk);
    #1 g_rst = 1'b0;
    @(negedge g_clk);
    check_value("busy", {31'd0, busy}, 32'd0);
    check_value("res_valid", {31'd0, res_valid}, 32'd0);
    check_value("res", res, 32'd0);
    @(posedge g_clk);
    #1;

    // every code against the corners, back to back
    for (int op = 0; op < 32; op++) begin
      for (int i = 0; i < 16; i++) begin
        if (5'(op) inside {fmax, fmin, feq, flt, fle}) begin
          for (int j = 0; j < 16; j++)
            issue_op(5'(op), specials[4'(i)], specials[4'(j)]);
        end else begin
          issue_op(5'(op), specials[4'(i)], pick_operand());
        end
      end
    end

    // random mix with idle gaps
    for (int n = 0; n < n_rand; n++) begin
      if ($urandom_range(3, 0) == 0)
        sel = 5'($urandom());   // unsupported codes too
      else
        sel = 5'(5 + $urandom_range(18, 0));
      issue_op(sel, pick_operand(), pick_operand());
      if ($urandom_range(3, 0) == 0) begin
        repeat ($urandom_range(2, 1)) @(posedge g_clk);
        #1;
      end
    end

    while (exp_q.size() != 0)
      @(negedge g_clk);
    repeat (2) @(posedge g_clk);
    check_value("results", results, n_tests);   // one result per request, none repeated

    $display("errors: %0d of %0d checks, %0d requests accepted, %0d results",
             errors, checks, accepts, results);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire
